//--- Bender.yml
package:
  name: bitmanip
  description: "RV32 bit-manipulation execution subsystem"

sources:
  # RTL in compile order
  - files:
      - logic/bitmanip_pkg.sv
      - logic/bitmanip_issue_if.sv
      - logic/bitmanip_decoder.sv
      - logic/bitmanip_ctrl.sv
      - logic/clmul_step_counter.sv
      - logic/clmul_unit.sv
      - logic/bitmanip_exec.sv
      - logic/bitmanip_top.sv
  # Testbench, top module tb_bitmanip
  - target: test
    files:
      - testbench/tb_bitmanip.sv

//--- all.f
logic/bitmanip_pkg.sv
logic/bitmanip_issue_if.sv
logic/bitmanip_decoder.sv
logic/bitmanip_ctrl.sv
logic/clmul_step_counter.sv
logic/clmul_unit.sv
logic/bitmanip_exec.sv
logic/bitmanip_top.sv
testbench/tb_bitmanip.sv

//--- logic/bitmanip_ctrl.sv
// One instruction in flight; valid_i outside IDLE is dropped, there is no back-pressure
`timescale 1ns/1ps

module bitmanip_ctrl (
  input  logic           clk,
  input  logic           reset_i,
  input  logic           valid_i,
  bitmanip_issue_if.ctrl issue,
  input  logic           last_step_i,
  output logic           count_en_o,
  output logic           load_o,
  output logic           done_o,
  output logic           busy_o
);
  import bitmanip_pkg::*;

  ctrl_state_e state_q, state_d;

  always_comb begin
    state_d    = state_q;
    count_en_o = 1'b0;
    load_o     = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (valid_i) begin
          if (issue.multi_cycle && !issue.illegal) begin
            state_d = MULT;               // Counter starts next cycle
          end else begin
            state_d = EXEC;
            load_o  = 1'b1;               // Single-cycle and illegal capture now
          end
        end
      end
      MULT: begin
        count_en_o = 1'b1;
        if (last_step_i) begin
          state_d = EXEC;
          load_o  = 1'b1;                 // Product completes on this step
        end
      end
      EXEC:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign done_o = (state_q == EXEC);     // Registered, one pulse per op
  assign busy_o = (state_q == MULT);

  ////////////////////
  // Checks
  ////////////////////
  a_valid_in_idle: assert property (@(posedge clk) disable iff (reset_i)
    valid_i |-> state_q == IDLE) else $error("valid_i while busy");
  a_done_pulse: assert property (@(posedge clk) disable iff (reset_i)
    done_o |=> !done_o) else $error("done_o longer than one cycle");
  // Counter must only reach its last step while this FSM is multiplying
  a_last_in_mult: assert property (@(posedge clk) disable iff (reset_i)
    last_step_i |-> state_q == MULT) else $error("last step outside MULT");

endmodule : bitmanip_ctrl

//--- logic/bitmanip_decoder.sv
// Decodes only OP and OP-IMM bit-manipulation forms; every other encoding comes out illegal
`timescale 1ns/1ps

module bitmanip_decoder #(
  parameter bitmanip_pkg::b_ext_e B_EXT = bitmanip_pkg::ZBA_ZBB_ZBC_ZBS
) (
  input bitmanip_pkg::instr_t instr_i,
  bitmanip_issue_if.decoder   issue
);
  import bitmanip_pkg::*;

  // Subset enables from the build choice
  localparam bit HAS_ZBA = (B_EXT == ZBA_ZBB_ZBS) || (B_EXT == ZBA_ZBB_ZBC_ZBS);
  localparam bit HAS_ZBB = (B_EXT == ZBA_ZBB_ZBS) || (B_EXT == ZBA_ZBB_ZBC_ZBS);
  localparam bit HAS_ZBS = (B_EXT == ZBA_ZBB_ZBS) || (B_EXT == ZBA_ZBB_ZBC_ZBS);
  localparam bit HAS_ZBC = (B_EXT == ZBA_ZBB_ZBC_ZBS);

  logic [6:0]   funct7;
  logic [2:0]   funct3;
  shamt_t       rs2_field;   // Also the immediate index/shamt
  bitmanip_op_e op;          // Raw match before subset gating
  logic         imm;
  logic         en;          // Matched op belongs to an enabled subset

  assign funct7    = instr_i[31:25];
  assign funct3    = instr_i[14:12];
  assign rs2_field = instr_i[24:20];

  ////////////////////
  // Encoding match
  ////////////////////
  always_comb begin
    op  = NOP;
    imm = 1'b0;
    unique case (instr_i[6:0])
      OPCODE_OP: begin
        unique case ({funct7, funct3})
          {7'b0010000, 3'b010}: op = SH1ADD;
          {7'b0010000, 3'b100}: op = SH2ADD;
          {7'b0010000, 3'b110}: op = SH3ADD;
          {7'b0000101, 3'b100}: op = MIN;
          {7'b0000101, 3'b101}: op = MINU;
          {7'b0000101, 3'b110}: op = MAX;
          {7'b0000101, 3'b111}: op = MAXU;
          {7'b0100000, 3'b111}: op = ANDN;
          {7'b0100000, 3'b110}: op = ORN;
          {7'b0100000, 3'b100}: op = XNOR;
          {7'b0110000, 3'b001}: op = ROL;
          {7'b0110000, 3'b101}: op = ROR;
          {7'b0000100, 3'b100}: op = (rs2_field == '0) ? ZEXT_H : NOP;  // rs2 hardwired to x0
          {7'b0000101, 3'b001}: op = CLMUL;
          {7'b0000101, 3'b011}: op = CLMULH;
          {7'b0000101, 3'b010}: op = CLMULR;
          {7'b0010100, 3'b001}: op = BSET;
          {7'b0100100, 3'b001}: op = BCLR;
          {7'b0110100, 3'b001}: op = BINV;
          {7'b0100100, 3'b101}: op = BEXT;
          default:              op = NOP;
        endcase
      end
      OPCODE_OPIMM: begin
        // Unary forms are told apart by the rs2 field
        unique casez ({funct7, rs2_field, funct3})
          {7'b0110000, 5'b00000, 3'b001}: op = CLZ;
          {7'b0110000, 5'b00001, 3'b001}: op = CTZ;
          {7'b0110000, 5'b00010, 3'b001}: op = CPOP;
          {7'b0110000, 5'b00100, 3'b001}: op = SEXT_B;
          {7'b0110000, 5'b00101, 3'b001}: op = SEXT_H;
          {7'b0010100, 5'b00111, 3'b101}: op = ORC_B;
          {7'b0110100, 5'b11000, 3'b101}: op = REV8;
          {7'b0110000, 5'b?????, 3'b101}: op = ROR;    // rori
          {7'b0010100, 5'b?????, 3'b001}: op = BSET;   // bseti
          {7'b0100100, 5'b?????, 3'b001}: op = BCLR;   // bclri
          {7'b0110100, 5'b?????, 3'b001}: op = BINV;   // binvi
          {7'b0100100, 5'b?????, 3'b101}: op = BEXT;   // bexti
          default:                        op = NOP;
        endcase
        imm = op inside {ROR, BSET, BCLR, BINV, BEXT};
      end
      default: op = NOP;  // Foreign opcode
    endcase
  end

  // Subset gating per operator group
  always_comb begin
    unique case (op)
      SH1ADD, SH2ADD, SH3ADD:  en = HAS_ZBA;
      BSET, BCLR, BINV, BEXT:  en = HAS_ZBS;
      CLMUL, CLMULH, CLMULR:   en = HAS_ZBC;
      NOP:                     en = 1'b0;
      default:                 en = HAS_ZBB;
    endcase
  end

  assign issue.illegal     = (op == NOP) || !en;
  assign issue.operator    = issue.illegal ? NOP : op;
  assign issue.use_imm     = !issue.illegal && imm;
  assign issue.multi_cycle = HAS_ZBC && (op inside {CLMUL, CLMULH, CLMULR});

  // Controller relies on an illegal op never taking the multiply path
  a_illegal_not_multi: assert final (!(issue.illegal && issue.multi_cycle))
    else $error("decoder flags an illegal op as multi-cycle");

endmodule : bitmanip_decoder

//--- logic/bitmanip_exec.sv
// Single-cycle ALU; clmul results are only selected here, the product comes from clmul_unit
`timescale 1ns/1ps

module bitmanip_exec (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 load_i,
  bitmanip_issue_if.exec       issue,
  input  bitmanip_pkg::instr_t instr_i,
  input  bitmanip_pkg::word_t  rs1_i,
  input  bitmanip_pkg::word_t  rs2_i,
  input  bitmanip_pkg::dword_t product_i,
  output bitmanip_pkg::word_t  result_o,
  output logic                 illegal_o
);
  import bitmanip_pkg::*;

  // Zeros below the first set bit
  function automatic word_t trailing_zeros(word_t v);
    word_t n;
    logic  seen;
    n    = '0;
    seen = 1'b0;
    for (int i = 0; i < XLEN; i++) begin
      seen = seen | v[i];
      n    = n + word_t'(!seen);
    end
    return n;
  endfunction

  word_t  op_b;
  shamt_t shamt;
  word_t  bit_mask;   // One-hot at shamt
  word_t  rs1_rev;    // Bit-reversed, clz via ctz
  word_t  orc_b;
  dword_t rot_l, rot_r;
  word_t  alu_res;
  word_t  result_q;
  logic   illegal_q;

  assign op_b     = issue.use_imm ? word_t'(instr_i[24:20]) : rs2_i;
  assign shamt    = op_b[4:0];
  assign bit_mask = word_t'(1) << shamt;
  assign rs1_rev  = {<<{rs1_i}};
  assign rot_l    = {rs1_i, rs1_i} << shamt;   // Upper half is rol
  assign rot_r    = {rs1_i, rs1_i} >> shamt;   // Lower half is ror

  always_comb begin
    for (int i = 0; i < XLEN / 8; i++) begin
      orc_b[8*i +: 8] = (|rs1_i[8*i +: 8]) ? 8'hff : 8'h00;
    end
  end

  ////////////////////
  // Operator select
  ////////////////////
  always_comb begin
    unique case (issue.operator)
      SH1ADD:  alu_res = (rs1_i << 1) + op_b;
      SH2ADD:  alu_res = (rs1_i << 2) + op_b;
      SH3ADD:  alu_res = (rs1_i << 3) + op_b;
      MIN:     alu_res = ($signed(rs1_i) < $signed(op_b)) ? rs1_i : op_b;
      MINU:    alu_res = (rs1_i < op_b) ? rs1_i : op_b;
      MAX:     alu_res = ($signed(rs1_i) < $signed(op_b)) ? op_b : rs1_i;
      MAXU:    alu_res = (rs1_i < op_b) ? op_b : rs1_i;
      ANDN:    alu_res = rs1_i & ~op_b;
      ORN:     alu_res = rs1_i | ~op_b;
      XNOR:    alu_res = ~(rs1_i ^ op_b);
      ROL:     alu_res = rot_l[2*XLEN-1:XLEN];
      ROR:     alu_res = rot_r[XLEN-1:0];
      ZEXT_H:  alu_res = {16'h0000, rs1_i[15:0]};
      SEXT_B:  alu_res = {{24{rs1_i[7]}}, rs1_i[7:0]};
      SEXT_H:  alu_res = {{16{rs1_i[15]}}, rs1_i[15:0]};
      CLZ:     alu_res = trailing_zeros(rs1_rev);
      CTZ:     alu_res = trailing_zeros(rs1_i);
      CPOP:    alu_res = word_t'($countones(rs1_i));
      ORC_B:   alu_res = orc_b;
      REV8:    alu_res = {rs1_i[7:0], rs1_i[15:8], rs1_i[23:16], rs1_i[31:24]};
      BSET:    alu_res = rs1_i | bit_mask;
      BCLR:    alu_res = rs1_i & ~bit_mask;
      BINV:    alu_res = rs1_i ^ bit_mask;
      BEXT:    alu_res = word_t'(rs1_i[shamt]);
      CLMUL:   alu_res = product_i[XLEN-1:0];
      CLMULH:  alu_res = product_i[2*XLEN-1:XLEN];
      CLMULR:  alu_res = product_i[2*XLEN-2:XLEN-1];
      default: alu_res = '0;                       // NOP
    endcase
  end

  // Result and flag hold until the next load
  always_ff @(posedge clk) begin
    if (reset_i) begin
      result_q  <= '0;
      illegal_q <= 1'b0;
    end else if (load_i) begin
      result_q  <= issue.illegal ? '0 : alu_res;
      illegal_q <= issue.illegal;
    end
  end

  assign result_o  = result_q;
  assign illegal_o = illegal_q;

endmodule : bitmanip_exec

//--- logic/bitmanip_issue_if.sv
// Combinational decode record, valid only while instr_i is held stable; no handshake
`timescale 1ns/1ps

interface bitmanip_issue_if;
  import bitmanip_pkg::*;

  bitmanip_op_e operator;     // NOP when illegal
  logic         use_imm;      // Operand b from instr[24:20]
  logic         illegal;      // No legal match for this build
  logic         multi_cycle;  // Clmul family

  modport decoder (output operator, output use_imm, output illegal, output multi_cycle);
  modport ctrl    (input illegal, input multi_cycle);
  modport exec    (input operator, input use_imm, input illegal);

endinterface : bitmanip_issue_if

//--- logic/bitmanip_pkg.sv
// Shared types for an RV32-only design; widths below are fixed at 32 and not meant to be changed
package bitmanip_pkg;

  ////////////////////
  // Widths and counts
  ////////////////////
  localparam int unsigned XLEN        = 32;
  localparam int unsigned CLMUL_STEPS = 32;    // One multiplier bit per step

  // Major opcodes handled by the decoder
  localparam logic [6:0] OPCODE_OP    = 7'b0110011;
  localparam logic [6:0] OPCODE_OPIMM = 7'b0010011;

  typedef logic [XLEN-1:0]   word_t;           // Operand or result
  typedef logic [31:0]       instr_t;          // Raw instruction word
  typedef logic [4:0]        shamt_t;          // Shift amount or bit index
  typedef logic [4:0]        step_t;           // Multiply step index
  typedef logic [2*XLEN-1:0] dword_t;          // Full carry-less product

  ////////////////////
  // Enumerations
  ////////////////////

  // Extension subsets built into the decoder
  typedef enum logic [1:0] {
    NONE,
    ZBA_ZBB_ZBS,
    ZBA_ZBB_ZBC_ZBS
  } b_ext_e;

  // Operator carried in the decoded record
  typedef enum logic [5:0] {
    SH1ADD, SH2ADD, SH3ADD,                    // Zba
    MIN, MINU, MAX, MAXU,                      // Zbb compare
    ANDN, ORN, XNOR,                           // Zbb logic with negate
    ROL, ROR,                                  // Zbb rotates
    ZEXT_H, SEXT_B, SEXT_H,                    // Zbb extends
    CLZ, CTZ, CPOP,                            // Zbb counts
    ORC_B, REV8,                               // Zbb byte ops
    BSET, BCLR, BINV, BEXT,                    // Zbs
    CLMUL, CLMULH, CLMULR,                     // Zbc, multi-cycle
    NOP                                        // Illegal or no match
  } bitmanip_op_e;

  // Controller FSM
  typedef enum logic [1:0] {
    IDLE,   // Waiting for valid_i
    EXEC,   // Result registered, done this cycle
    MULT    // Carry-less multiply iterating
  } ctrl_state_e;

endpackage : bitmanip_pkg

//--- logic/bitmanip_top.sv
// Caller holds instr_i, rs1_i and rs2_i stable from valid_i until done_o; one op at a time
`timescale 1ns/1ps

module bitmanip_top #(
  parameter bitmanip_pkg::b_ext_e B_EXT = bitmanip_pkg::ZBA_ZBB_ZBC_ZBS
) (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 valid_i,     // Single-cycle start pulse
  input  bitmanip_pkg::instr_t instr_i,
  input  bitmanip_pkg::word_t  rs1_i,
  input  bitmanip_pkg::word_t  rs2_i,
  output bitmanip_pkg::word_t  result_o,
  output logic                 illegal_o,
  output logic                 done_o,      // Single-cycle end pulse
  output logic                 busy_o
);
  import bitmanip_pkg::*;

  logic   count_en;
  logic   load;
  logic   last_step;
  logic   mult_start;   // First MULT cycle
  step_t  step;
  dword_t product;

  bitmanip_issue_if issue ();

  // Counter sits at 0 only on entry to MULT
  assign mult_start = count_en && (step == '0);

  bitmanip_decoder #(.B_EXT(B_EXT)) i_decoder (.instr_i(instr_i), .issue(issue));

  bitmanip_ctrl i_ctrl (
    .clk, .reset_i, .valid_i, .issue(issue), .last_step_i(last_step),
    .count_en_o(count_en), .load_o(load), .done_o, .busy_o
  );

  clmul_step_counter i_counter (
    .clk, .reset_i, .count_en_i(count_en), .step_o(step), .last_step_o(last_step)
  );

  clmul_unit i_clmul (
    .clk, .reset_i, .start_i(mult_start), .step_en_i(count_en), .step_i(step),
    .op_a_i(rs1_i), .op_b_i(rs2_i), .product_o(product)
  );

  bitmanip_exec i_exec (
    .clk, .reset_i, .load_i(load), .issue(issue), .instr_i, .rs1_i, .rs2_i,
    .product_i(product), .result_o, .illegal_o
  );

endmodule : bitmanip_top

//--- logic/clmul_step_counter.sv
// Fixed 32-step sequence; wraps to 0 after the last step so it is ready for the next multiply
`timescale 1ns/1ps

module clmul_step_counter (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                count_en_i,
  output bitmanip_pkg::step_t step_o,
  output logic                last_step_o
);
  import bitmanip_pkg::*;

  step_t step_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      step_q <= '0;
    end else if (count_en_i) begin
      step_q <= step_q + step_t'(1);     // 31 rolls over to 0
    end
  end

  assign step_o      = step_q;
  assign last_step_o = (step_q == step_t'(CLMUL_STEPS - 1));

endmodule : clmul_step_counter

//--- logic/clmul_unit.sv
// Operands must stay stable for all 32 steps; product_o already includes the step in progress
`timescale 1ns/1ps

module clmul_unit (
  input  logic                 clk,
  input  logic                 reset_i,
  input  logic                 start_i,
  input  logic                 step_en_i,
  input  bitmanip_pkg::step_t  step_i,
  input  bitmanip_pkg::word_t  op_a_i,
  input  bitmanip_pkg::word_t  op_b_i,
  output bitmanip_pkg::dword_t product_o
);
  import bitmanip_pkg::*;

  dword_t acc_q;
  dword_t acc_d;
  dword_t partial;   // op_a shifted to this step, if op_b bit is set

  always_comb begin
    partial = op_b_i[step_i] ? (dword_t'(op_a_i) << step_i) : '0;
    acc_d   = (start_i ? '0 : acc_q) ^ partial;   // First step drops the old product
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      acc_q <= '0;
    end else if (step_en_i) begin
      acc_q <= acc_d;
    end
  end

  // Complete during the last step, held afterwards
  assign product_o = step_en_i ? acc_d : acc_q;

endmodule : clmul_unit

//--- testbench/tb_bitmanip.sv
// Runs only the full Zba/Zbb/Zbc/Zbs build; operands come from $random with a fixed seed
`timescale 1ns/1ps

module tb_bitmanip;
  import bitmanip_pkg::*;

  localparam int NUM_OPS = 79;   // Operations issued over all tests
  localparam int MAX_LAT = 40;   // Wait limit per op, in cycles

  logic   clk = 1'b0;
  logic   reset_i;
  logic   valid_i;
  instr_t instr_i;
  word_t  rs1_i;
  word_t  rs2_i;
  word_t  result_o;
  logic   illegal_o;
  logic   done_o;
  logic   busy_o;

  integer seed       = 32'h9bbbc301;
  int     mismatches = 0;
  int     failures   = 0;          // Timeouts and missing done_o

  bitmanip_top #(.B_EXT(ZBA_ZBB_ZBC_ZBS)) i_dut (
    .clk, .reset_i, .valid_i, .instr_i, .rs1_i, .rs2_i,
    .result_o, .illegal_o, .done_o, .busy_o
  );

  always #4 clk = ~clk;            // 8 ns period

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      mismatches++;
      $display("MISMATCH %s latency: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  ////////////////////
  // Encodings
  ////////////////////
  function automatic instr_t encode(logic [6:0] f7, shamt_t rs2f, logic [2:0] f3,
                                    logic [6:0] opc);
    return {f7, rs2f, 5'd1, f3, 5'd3, opc};   // rs1 = x1, rd = x3
  endfunction

  // Register forms under OP
  function automatic instr_t op_encoding(bitmanip_op_e op);
    case (op)
      SH1ADD:  return encode(7'b0010000, 5'd2, 3'b010, OPCODE_OP);
      SH2ADD:  return encode(7'b0010000, 5'd2, 3'b100, OPCODE_OP);
      SH3ADD:  return encode(7'b0010000, 5'd2, 3'b110, OPCODE_OP);
      MIN:     return encode(7'b0000101, 5'd2, 3'b100, OPCODE_OP);
      MINU:    return encode(7'b0000101, 5'd2, 3'b101, OPCODE_OP);
      MAX:     return encode(7'b0000101, 5'd2, 3'b110, OPCODE_OP);
      MAXU:    return encode(7'b0000101, 5'd2, 3'b111, OPCODE_OP);
      ANDN:    return encode(7'b0100000, 5'd2, 3'b111, OPCODE_OP);
      ORN:     return encode(7'b0100000, 5'd2, 3'b110, OPCODE_OP);
      XNOR:    return encode(7'b0100000, 5'd2, 3'b100, OPCODE_OP);
      ROL:     return encode(7'b0110000, 5'd2, 3'b001, OPCODE_OP);
      ROR:     return encode(7'b0110000, 5'd2, 3'b101, OPCODE_OP);
      ZEXT_H:  return encode(7'b0000100, 5'd0, 3'b100, OPCODE_OP);   // rs2 must be x0
      CLMUL:   return encode(7'b0000101, 5'd2, 3'b001, OPCODE_OP);
      CLMULH:  return encode(7'b0000101, 5'd2, 3'b011, OPCODE_OP);
      CLMULR:  return encode(7'b0000101, 5'd2, 3'b010, OPCODE_OP);
      BSET:    return encode(7'b0010100, 5'd2, 3'b001, OPCODE_OP);
      BCLR:    return encode(7'b0100100, 5'd2, 3'b001, OPCODE_OP);
      BINV:    return encode(7'b0110100, 5'd2, 3'b001, OPCODE_OP);
      BEXT:    return encode(7'b0100100, 5'd2, 3'b101, OPCODE_OP);
      default: return '0;
    endcase
  endfunction

  // Unary and immediate forms under OP-IMM
  function automatic instr_t imm_encoding(bitmanip_op_e op, shamt_t imm);
    case (op)
      CLZ:     return encode(7'b0110000, 5'd0, 3'b001, OPCODE_OPIMM);
      CTZ:     return encode(7'b0110000, 5'd1, 3'b001, OPCODE_OPIMM);
      CPOP:    return encode(7'b0110000, 5'd2, 3'b001, OPCODE_OPIMM);
      SEXT_B:  return encode(7'b0110000, 5'd4, 3'b001, OPCODE_OPIMM);
      SEXT_H:  return encode(7'b0110000, 5'd5, 3'b001, OPCODE_OPIMM);
      ORC_B:   return encode(7'b0010100, 5'b00111, 3'b101, OPCODE_OPIMM);
      REV8:    return encode(7'b0110100, 5'b11000, 3'b101, OPCODE_OPIMM);
      ROR:     return encode(7'b0110000, imm, 3'b101, OPCODE_OPIMM);   // rori
      BSET:    return encode(7'b0010100, imm, 3'b001, OPCODE_OPIMM);
      BCLR:    return encode(7'b0100100, imm, 3'b001, OPCODE_OPIMM);
      BINV:    return encode(7'b0110100, imm, 3'b001, OPCODE_OPIMM);
      BEXT:    return encode(7'b0100100, imm, 3'b101, OPCODE_OPIMM);
      default: return '0;
    endcase
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  function automatic word_t model(bitmanip_op_e op, word_t a, word_t b);
    word_t  r;
    dword_t p;   // Carry-less product, bit by bit
    int     s;
    r = '0;
    p = '0;
    s = int'(b[4:0]);
    for (int i = 0; i < 32; i++) begin
      if (b[i]) p = p ^ (dword_t'(a) << i);
    end
    case (op)
      SH1ADD: r = (a << 1) + b;
      SH2ADD: r = (a << 2) + b;
      SH3ADD: r = (a << 3) + b;
      MIN:    r = ($signed(a) < $signed(b)) ? a : b;
      MINU:   r = (a < b) ? a : b;
      MAX:    r = ($signed(a) > $signed(b)) ? a : b;
      MAXU:   r = (a > b) ? a : b;
      ANDN:   r = a & ~b;
      ORN:    r = a | ~b;
      XNOR:   r = a ^ ~b;
      ROL:    r = (a << s) | (a >> (32 - s));   // Shift by 32 gives 0
      ROR:    r = (a >> s) | (a << (32 - s));
      ZEXT_H: r = a & 32'h0000_ffff;
      SEXT_B: r = a[7] ? (a | 32'hffff_ff00) : (a & 32'h0000_00ff);
      SEXT_H: r = a[15] ? (a | 32'hffff_0000) : (a & 32'h0000_ffff);
      CLZ: begin
        r = 32;
        for (int i = 0; i < 32; i++) if (a[i]) r = word_t'(31 - i);   // Highest set bit wins
      end
      CTZ: begin
        r = 32;
        for (int i = 31; i >= 0; i--) if (a[i]) r = word_t'(i);
      end
      CPOP:   for (int i = 0; i < 32; i++) r = r + word_t'(a[i]);
      ORC_B:  for (int k = 0; k < 4; k++) if (a[8*k +: 8] != 8'h00) r[8*k +: 8] = 8'hff;
      REV8:   for (int k = 0; k < 4; k++) r[8*k +: 8] = a[8*(3-k) +: 8];
      BSET:   r = a | (32'd1 << s);
      BCLR:   r = a & ~(32'd1 << s);
      BINV:   r = a ^ (32'd1 << s);
      BEXT:   r = (a >> s) & 32'd1;
      CLMUL:  r = p[31:0];
      CLMULH: r = p[63:32];
      CLMULR: r = p[62:31];
      default: r = '0;
    endcase
    return r;
  endfunction

  ////////////////////
  // Issue one op, wait for done_o and check everything
  ////////////////////
  task automatic run_op(input string name, input instr_t instr, input word_t a, input word_t b,
                        input word_t exp_res, input logic exp_ill, input int exp_lat);
    int cycles;
    cycles = 0;
    @(negedge clk);
    instr_i = instr;
    rs1_i   = a;
    rs2_i   = b;
    valid_i = 1'b1;
    @(negedge clk);
    valid_i = 1'b0;
    cycles  = 1;
    while (done_o !== 1'b1 && cycles < MAX_LAT) begin
      check_flag({name, " busy_o"}, exp_lat > 1, busy_o);   // High only while multiplying
      @(negedge clk);
      cycles++;
    end
    if (done_o !== 1'b1) begin
      failures++;
      $display("ERROR %s: done_o did not arrive within %0d cycles", name, MAX_LAT);
    end else begin
      check_latency(name, exp_lat, cycles);
      check_word(name, exp_res, result_o);
      check_flag({name, " illegal_o"}, exp_ill, illegal_o);
      check_flag({name, " busy_o at done"}, 1'b0, busy_o);
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic test_reset_idle();
    check_flag("reset done_o", 1'b0, done_o);
    check_flag("reset busy_o", 1'b0, busy_o);
    check_flag("reset illegal_o", 1'b0, illegal_o);
    check_word("reset result_o", '0, result_o);
  endtask

  task automatic test_reg_ops();
    bitmanip_op_e ops[13] = '{SH1ADD, SH2ADD, SH3ADD, MIN, MINU, MAX, MAXU,
                              ANDN, ORN, XNOR, ROL, ROR, ZEXT_H};
    word_t a;
    word_t b;
    foreach (ops[i]) begin
      repeat (2) begin
        a = word_t'($random(seed));
        b = word_t'($random(seed));
        run_op(ops[i].name(), op_encoding(ops[i]), a, b, model(ops[i], a, b), 1'b0, 1);
      end
    end
  endtask

  task automatic test_unary_imm();
    bitmanip_op_e ops[7] = '{CLZ, CTZ, CPOP, ORC_B, REV8, SEXT_B, SEXT_H};
    word_t  a;
    word_t  b;
    shamt_t imm;
    foreach (ops[i]) begin
      for (int k = 0; k < 3; k++) begin
        a = (k == 0) ? 32'h0 : (k == 1) ? 32'hffff_ffff : word_t'($random(seed));
        b = word_t'($random(seed));   // Ignored by unary forms
        run_op(ops[i].name(), imm_encoding(ops[i], 5'd0), a, b, model(ops[i], a, 32'h0),
               1'b0, 1);
      end
    end
    for (int k = 0; k < 3; k++) begin
      a      = (k == 0) ? 32'h0 : (k == 1) ? 32'hffff_ffff : word_t'($random(seed));
      imm    = shamt_t'($random(seed));
      b      = word_t'($random(seed));
      b[4:0] = imm + 5'd11;          // rs2 amount differs from the immediate
      run_op("rori", imm_encoding(ROR, imm), a, b, model(ROR, a, word_t'(imm)), 1'b0, 1);
    end
  endtask

  task automatic test_single_bit();
    bitmanip_op_e ops[4] = '{BSET, BCLR, BINV, BEXT};
    word_t  a;
    word_t  b;
    shamt_t imm;
    foreach (ops[i]) begin
      repeat (2) begin
        a   = word_t'($random(seed));
        b   = word_t'($random(seed));
        imm = b[4:0] + 5'd7;            // Never equal to the rs2 index
        run_op(ops[i].name(), op_encoding(ops[i]), a, b, model(ops[i], a, b), 1'b0, 1);
        run_op({ops[i].name(), "I"}, imm_encoding(ops[i], imm), a, b,
               model(ops[i], a, word_t'(imm)), 1'b0, 1);
      end
    end
  endtask

  task automatic test_clmul();
    bitmanip_op_e ops[3] = '{CLMUL, CLMULH, CLMULR};
    word_t a;
    word_t b;
    foreach (ops[i]) begin
      repeat (3) begin
        a = word_t'($random(seed));
        b = word_t'($random(seed));
        run_op(ops[i].name(), op_encoding(ops[i]), a, b, model(ops[i], a, b), 1'b0, 33);
      end
    end
  endtask

  task automatic test_illegal();
    word_t a;
    word_t b;
    a = word_t'($random(seed));
    b = word_t'($random(seed));
    run_op("bad funct7", encode(7'b1111111, 5'd2, 3'b000, OPCODE_OP), a, b, '0, 1'b1, 1);
    run_op("zext.h rs2", encode(7'b0000100, 5'd3, 3'b100, OPCODE_OP), a, b, '0, 1'b1, 1);
    run_op("lui opcode", encode(7'b0100000, 5'd2, 3'b111, 7'b0110111), a, b, '0, 1'b1, 1);
    // Legal op right after must be unaffected
    run_op("andn after illegal", op_encoding(ANDN), a, b, model(ANDN, a, b), 1'b0, 1);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    reset_i = 1'b1;
    valid_i = 1'b0;
    instr_i = '0;
    rs1_i   = '0;
    rs2_i   = '0;
    repeat (2) @(posedge clk);   // Two reset cycles
    @(negedge clk);
    reset_i = 1'b0;
    test_reset_idle();
    test_reg_ops();
    test_unary_imm();
    test_single_bit();
    test_clmul();
    test_illegal();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Worst case 40 cycles per op plus reset margin
  initial begin
    repeat (NUM_OPS * MAX_LAT + 100) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, the run did not complete",
             NUM_OPS * MAX_LAT + 100);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule : tb_bitmanip
